// File: verilog/vrf_arb_pkg.sv
package vrf_arb_pkg;

    ////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////

    // BRAM word address, 1024 vectors deep
    localparam int VRF_ADDR_W = 10;
    // one vector register per BRAM word
    localparam int VRF_DATA_W = 1024;
    localparam int NUM_CLIENTS = 4;

    ////////////////////////////////////////////////////////////
    // client identity and port ownership
    ////////////////////////////////////////////////////////////

    // encoding order is also the fixed grant priority
    typedef enum logic [1:0] {
        CLI_VPU    = 2'd0,
        CLI_MPU    = 2'd1,
        CLI_MA     = 2'd2,
        CLI_ROUTER = 2'd3
    } client_e;

    // busy low means the port is idle and id is ignored
    typedef struct packed {
        logic    busy;
        client_e id;
    } owner_t;

    ////////////////////////////////////////////////////////////
    // request and BRAM command words
    ////////////////////////////////////////////////////////////

    // held stable by the client until it drops the request
    typedef struct packed {
        logic                  rd_req;
        logic                  wr_req;
        logic [VRF_ADDR_W-1:0] rd_addr;
        logic [VRF_ADDR_W-1:0] wr_addr;
        logic [VRF_DATA_W-1:0] wr_data;
    } client_req_t;

    // one BRAM port, dout comes back separately
    typedef struct packed {
        logic                  en;
        logic                  we;
        logic [VRF_ADDR_W-1:0] addr;
        logic [VRF_DATA_W-1:0] din;
    } bram_req_t;

endpackage

// File: verilog/port_owner_ctrl.sv
`timescale 1ns/1ps

module port_owner_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  vrf_arb_pkg::client_req_t  cli_req_i [vrf_arb_pkg::NUM_CLIENTS],
    output vrf_arb_pkg::owner_t       owner_a_o,
    output vrf_arb_pkg::owner_t       owner_b_o
);

    vrf_arb_pkg::owner_t owner_a_q;
    vrf_arb_pkg::owner_t owner_b_q;
    vrf_arb_pkg::owner_t owner_a_d;
    vrf_arb_pkg::owner_t owner_b_d;

    logic [vrf_arb_pkg::NUM_CLIENTS-1:0] any_req;
    logic                                vpu_rd;

    // first requester in priority order, skipping whoever holds the other port
    function automatic vrf_arb_pkg::owner_t pick_first(
        input logic [vrf_arb_pkg::NUM_CLIENTS-1:0] req,
        input vrf_arb_pkg::owner_t                 excl
    );
        vrf_arb_pkg::owner_t pick;
        logic                found;
        pick  = '0;
        found = 1'b0;
        for (int c = 0; c < vrf_arb_pkg::NUM_CLIENTS; c++) begin
            if (!found && req[c] &&
                !(excl.busy && excl.id == vrf_arb_pkg::client_e'(c))) begin
                pick.busy = 1'b1;
                pick.id   = vrf_arb_pkg::client_e'(c);
                found     = 1'b1;
            end
        end
        return pick;
    endfunction

    // owner keeps the port while either request is up
    function automatic vrf_arb_pkg::owner_t hold_or_free(
        input vrf_arb_pkg::owner_t                 cur,
        input logic [vrf_arb_pkg::NUM_CLIENTS-1:0] req
    );
        vrf_arb_pkg::owner_t nxt;
        nxt = cur;
        if (!req[cur.id]) begin
            nxt = '0;
        end
        return nxt;
    endfunction

    always_comb begin
        for (int c = 0; c < vrf_arb_pkg::NUM_CLIENTS; c++) begin
            any_req[c] = cli_req_i[c].rd_req | cli_req_i[c].wr_req;
        end
    end

    assign vpu_rd = cli_req_i[vrf_arb_pkg::CLI_VPU].rd_req;

    ////////////////////////////////////////////////////////////
    // next owner, port A
    ////////////////////////////////////////////////////////////

    always_comb begin
        owner_a_d = '0;
        if (owner_a_q.busy) begin
            owner_a_d = hold_or_free(owner_a_q, any_req);
        end else if (vpu_rd) begin
            // dual operand read needs both ports free at once
            if (!owner_b_q.busy) begin
                owner_a_d.busy = 1'b1;
                owner_a_d.id   = vrf_arb_pkg::CLI_VPU;
            end
        end else begin
            owner_a_d = pick_first(any_req, owner_b_q);
        end
    end

    ////////////////////////////////////////////////////////////
    // next owner, port B
    ////////////////////////////////////////////////////////////

    always_comb begin
        owner_b_d = '0;
        if (owner_b_q.busy) begin
            owner_b_d = hold_or_free(owner_b_q, any_req);
        end else if (vpu_rd) begin
            if (!owner_a_q.busy) begin
                owner_b_d.busy = 1'b1;
                owner_b_d.id   = vrf_arb_pkg::CLI_VPU;
            end
        end else begin
            // looks at A's next owner so one client never lands on both
            owner_b_d = pick_first(any_req, owner_a_d);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner_a_q <= '0;
            owner_b_q <= '0;
        end else begin
            owner_a_q <= owner_a_d;
            owner_b_q <= owner_b_d;
        end
    end

    assign owner_a_o = owner_a_q;
    assign owner_b_o = owner_b_q;

endmodule

// File: verilog/bram_port_mux.sv
`timescale 1ns/1ps

module bram_port_mux (
    input  vrf_arb_pkg::owner_t                 owner_i,
    input  vrf_arb_pkg::client_req_t            cli_req_i [vrf_arb_pkg::NUM_CLIENTS],
    input  logic [vrf_arb_pkg::VRF_ADDR_W-1:0]  vpu_rd_addr_i,
    output vrf_arb_pkg::bram_req_t              bram_o
);

    vrf_arb_pkg::client_req_t sel_req;
    logic                     sel_is_vpu;

    // request of whoever owns this port
    assign sel_req    = cli_req_i[owner_i.id];
    assign sel_is_vpu = (owner_i.id == vrf_arb_pkg::CLI_VPU);

    always_comb begin
        bram_o = '0;
        if (owner_i.busy) begin
            if (sel_req.rd_req) begin
                bram_o.en = 1'b1;
                bram_o.we = 1'b0;
                // VPU operand address differs per port
                if (sel_is_vpu) begin
                    bram_o.addr = vpu_rd_addr_i;
                end else begin
                    bram_o.addr = sel_req.rd_addr;
                end
            end else if (sel_req.wr_req) begin
                bram_o.en   = 1'b1;
                bram_o.we   = 1'b1;
                bram_o.addr = sel_req.wr_addr;
                bram_o.din  = sel_req.wr_data;
            end
        end
    end

endmodule

// File: verilog/grant_return.sv
`timescale 1ns/1ps

module grant_return (
    input  vrf_arb_pkg::owner_t                 owner_a_i,
    input  vrf_arb_pkg::owner_t                 owner_b_i,
    input  vrf_arb_pkg::client_req_t            cli_req_i [vrf_arb_pkg::NUM_CLIENTS],
    input  logic [vrf_arb_pkg::VRF_DATA_W-1:0]  bram_a_dout_i,
    input  logic [vrf_arb_pkg::VRF_DATA_W-1:0]  bram_b_dout_i,
    output logic [vrf_arb_pkg::NUM_CLIENTS-1:0] cli_rd_gnt_o,
    output logic [vrf_arb_pkg::NUM_CLIENTS-1:0] cli_wr_gnt_o,
    output logic [vrf_arb_pkg::VRF_DATA_W-1:0]  cli_rd_data_o [vrf_arb_pkg::NUM_CLIENTS],
    output logic [vrf_arb_pkg::VRF_DATA_W-1:0]  vpu_src2_data_o
);

    logic [vrf_arb_pkg::NUM_CLIENTS-1:0] own_a;
    logic [vrf_arb_pkg::NUM_CLIENTS-1:0] own_b;

    ////////////////////////////////////////////////////////////
    // ownership decode and grants
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int c = 0; c < vrf_arb_pkg::NUM_CLIENTS; c++) begin
            own_a[c] = owner_a_i.busy && (owner_a_i.id == vrf_arb_pkg::client_e'(c));
            own_b[c] = owner_b_i.busy && (owner_b_i.id == vrf_arb_pkg::client_e'(c));
        end
    end

    always_comb begin
        for (int c = 0; c < vrf_arb_pkg::NUM_CLIENTS; c++) begin
            // read wins when both are raised
            cli_rd_gnt_o[c] = (own_a[c] | own_b[c]) & cli_req_i[c].rd_req;
            cli_wr_gnt_o[c] = (own_a[c] | own_b[c]) & cli_req_i[c].wr_req
                              & ~cli_req_i[c].rd_req;
        end
    end

    ////////////////////////////////////////////////////////////
    // read data steering
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int c = 0; c < vrf_arb_pkg::NUM_CLIENTS; c++) begin
            if (own_a[c]) begin
                cli_rd_data_o[c] = bram_a_dout_i;
            end else if (own_b[c] && c != int'(vrf_arb_pkg::CLI_VPU)) begin
                cli_rd_data_o[c] = bram_b_dout_i;
            end else begin
                cli_rd_data_o[c] = '0;
            end
        end
    end

    // second VPU operand only ever comes from port B
    assign vpu_src2_data_o = own_b[vrf_arb_pkg::CLI_VPU] ? bram_b_dout_i : '0;

endmodule

// File: verilog/vrf_arbiter.sv
`timescale 1ns/1ps

module vrf_arbiter (
    input  logic                                clk,
    input  logic                                rst_n,
    input  vrf_arb_pkg::client_req_t            cli_req_i [vrf_arb_pkg::NUM_CLIENTS],
    input  logic [vrf_arb_pkg::VRF_ADDR_W-1:0]  vpu_src2_addr_i,
    output vrf_arb_pkg::bram_req_t              bram_a_o,
    output vrf_arb_pkg::bram_req_t              bram_b_o,
    input  logic [vrf_arb_pkg::VRF_DATA_W-1:0]  bram_a_dout_i,
    input  logic [vrf_arb_pkg::VRF_DATA_W-1:0]  bram_b_dout_i,
    output logic [vrf_arb_pkg::NUM_CLIENTS-1:0] cli_rd_gnt_o,
    output logic [vrf_arb_pkg::NUM_CLIENTS-1:0] cli_wr_gnt_o,
    output logic [vrf_arb_pkg::VRF_DATA_W-1:0]  cli_rd_data_o [vrf_arb_pkg::NUM_CLIENTS],
    output logic [vrf_arb_pkg::VRF_DATA_W-1:0]  vpu_src2_data_o
);

    vrf_arb_pkg::owner_t owner_a;
    vrf_arb_pkg::owner_t owner_b;

    port_owner_ctrl u_owner (
        .clk       (clk),
        .rst_n     (rst_n),
        .cli_req_i (cli_req_i),
        .owner_a_o (owner_a),
        .owner_b_o (owner_b)
    );

    // port A carries the first VPU operand
    bram_port_mux u_mux_a (
        .owner_i       (owner_a),
        .cli_req_i     (cli_req_i),
        .vpu_rd_addr_i (cli_req_i[vrf_arb_pkg::CLI_VPU].rd_addr),
        .bram_o        (bram_a_o)
    );

    // port B carries the second one
    bram_port_mux u_mux_b (
        .owner_i       (owner_b),
        .cli_req_i     (cli_req_i),
        .vpu_rd_addr_i (vpu_src2_addr_i),
        .bram_o        (bram_b_o)
    );

    grant_return u_gnt (
        .owner_a_i       (owner_a),
        .owner_b_i       (owner_b),
        .cli_req_i       (cli_req_i),
        .bram_a_dout_i   (bram_a_dout_i),
        .bram_b_dout_i   (bram_b_dout_i),
        .cli_rd_gnt_o    (cli_rd_gnt_o),
        .cli_wr_gnt_o    (cli_wr_gnt_o),
        .cli_rd_data_o   (cli_rd_data_o),
        .vpu_src2_data_o (vpu_src2_data_o)
    );

endmodule

// File: verif/vrf_arbiter_chk.sv
`timescale 1ns/1ps

module vrf_arbiter_chk (
    input logic                                clk,
    input logic                                rst_n,
    input vrf_arb_pkg::client_req_t            cli_req_i [vrf_arb_pkg::NUM_CLIENTS],
    input vrf_arb_pkg::bram_req_t              bram_a_o,
    input vrf_arb_pkg::bram_req_t              bram_b_o,
    input logic [vrf_arb_pkg::NUM_CLIENTS-1:0] cli_rd_gnt_o,
    input logic [vrf_arb_pkg::NUM_CLIENTS-1:0] cli_wr_gnt_o
);

    int                                  assert_fails = 0;
    logic [vrf_arb_pkg::NUM_CLIENTS-1:0] rd_req;
    logic [vrf_arb_pkg::NUM_CLIENTS-1:0] wr_req;

    always_comb begin
        for (int c = 0; c < vrf_arb_pkg::NUM_CLIENTS; c++) begin
            rd_req[c] = cli_req_i[c].rd_req;
            wr_req[c] = cli_req_i[c].wr_req;
        end
    end

    a_gnt_excl: assert property (@(posedge clk) disable iff (!rst_n)
        (cli_rd_gnt_o & cli_wr_gnt_o) == '0)
        else begin
            $error("client has read and write grant together");
            assert_fails++;
        end

    a_gnt_req: assert property (@(posedge clk) disable iff (!rst_n)
        ((cli_rd_gnt_o & ~rd_req) | (cli_wr_gnt_o & ~wr_req)) == '0)
        else begin
            $error("grant without matching request");
            assert_fails++;
        end

    a_we_en: assert property (@(posedge clk) disable iff (!rst_n)
        !(bram_a_o.we && !bram_a_o.en) && !(bram_b_o.we && !bram_b_o.en))
        else begin
            $error("BRAM we high with en low");
            assert_fails++;
        end

    a_en_gnt: assert property (@(posedge clk) disable iff (!rst_n)
        (bram_a_o.en || bram_b_o.en) |-> (cli_rd_gnt_o | cli_wr_gnt_o) != '0)
        else begin
            $error("BRAM port enabled with no client granted");
            assert_fails++;
        end

endmodule

bind vrf_arbiter vrf_arbiter_chk u_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .cli_req_i    (cli_req_i),
    .bram_a_o     (bram_a_o),
    .bram_b_o     (bram_b_o),
    .cli_rd_gnt_o (cli_rd_gnt_o),
    .cli_wr_gnt_o (cli_wr_gnt_o)
);

// File: verif/tb_vrf_arbiter.sv
`timescale 1ns/1ps

module tb_vrf_arbiter;

    localparam int CLK_PERIOD = 4;
    localparam int AW = vrf_arb_pkg::VRF_ADDR_W;
    localparam int DW = vrf_arb_pkg::VRF_DATA_W;
    localparam int NC = vrf_arb_pkg::NUM_CLIENTS;
    localparam int RAND_CYCLES = 300;
    // reset, write/read, VPU read, priority, random run, drain
    localparam int TOTAL_CYCLES = 8 + 20 + 12 + 30 + RAND_CYCLES + 10;

    logic                     clk;
    logic                     rst_n;
    vrf_arb_pkg::client_req_t cli_req [NC];
    logic [AW-1:0]            vpu_src2_addr;
    vrf_arb_pkg::bram_req_t   bram_a;
    vrf_arb_pkg::bram_req_t   bram_b;
    logic [DW-1:0]            dout_a = '0;
    logic [DW-1:0]            dout_b = '0;
    logic [NC-1:0]            rd_gnt;
    logic [NC-1:0]            wr_gnt;
    logic [DW-1:0]            rd_data [NC];
    logic [DW-1:0]            src2_data;

    logic [DW-1:0]            mem [1 << AW];
    vrf_arb_pkg::owner_t      ref_a;
    vrf_arb_pkg::owner_t      ref_b;
    logic [NC-1:0]            prev_rd;
    logic [AW-1:0]            prev_addr [NC];
    logic [DW-1:0]            prev_data [NC];
    logic                     prev_src2;
    logic [DW-1:0]            prev_src2_data;
    logic                     cmp_en;
    int                       seed = 32'hdc74;
    int                       errors = 0;
    int                       checks = 0;
    int                       tests = 0;

    vrf_arbiter UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .cli_req_i       (cli_req),
        .vpu_src2_addr_i (vpu_src2_addr),
        .bram_a_o        (bram_a),
        .bram_b_o        (bram_b),
        .bram_a_dout_i   (dout_a),
        .bram_b_dout_i   (dout_b),
        .cli_rd_gnt_o    (rd_gnt),
        .cli_wr_gnt_o    (wr_gnt),
        .cli_rd_data_o   (rd_data),
        .vpu_src2_data_o (src2_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // two synchronous ports on one array, write first per port
    always @(posedge clk) begin
        if (bram_a.en) begin
            if (bram_a.we) begin
                mem[bram_a.addr] <= bram_a.din;
            end
            dout_a <= bram_a.we ? bram_a.din : mem[bram_a.addr];
        end
        if (bram_b.en) begin
            if (bram_b.we) begin
                mem[bram_b.addr] <= bram_b.din;
            end
            dout_b <= bram_b.we ? bram_b.din : mem[bram_b.addr];
        end
    end

    ////////////////////////////////////////////////////////////
    // reference owner model
    ////////////////////////////////////////////////////////////

    function automatic logic owns(vrf_arb_pkg::owner_t o, int c);
        return o.busy && int'(o.id) == c;
    endfunction

    // excl is the client this port may not take
    function automatic vrf_arb_pkg::owner_t next_owner(vrf_arb_pkg::owner_t cur,
            vrf_arb_pkg::owner_t other, vrf_arb_pkg::owner_t excl);
        vrf_arb_pkg::owner_t nxt;
        nxt = '0;
        if (cur.busy) begin
            if (cli_req[cur.id].rd_req || cli_req[cur.id].wr_req) begin
                nxt = cur;
            end
        end else if (cli_req[0].rd_req) begin
            nxt.busy = !other.busy;
        end else begin
            // walk from lowest priority so the highest requester ends up chosen
            for (int c = NC - 1; c >= 0; c--) begin
                if ((cli_req[c].rd_req || cli_req[c].wr_req) && !owns(excl, c)) begin
                    nxt.busy = 1'b1;
                    nxt.id   = vrf_arb_pkg::client_e'(c);
                end
            end
        end
        return nxt;
    endfunction

    always @(posedge clk or negedge rst_n) begin : ref_owner
        vrf_arb_pkg::owner_t na;
        if (!rst_n) begin
            ref_a <= '0;
            ref_b <= '0;
        end else begin
            na = next_owner(ref_a, ref_b, ref_b);
            ref_a <= na;
            ref_b <= next_owner(ref_b, ref_a, na);
        end
    end

    function automatic vrf_arb_pkg::bram_req_t exp_cmd(vrf_arb_pkg::owner_t o, logic port_b);
        vrf_arb_pkg::bram_req_t   cmd;
        vrf_arb_pkg::client_req_t r;
        cmd = '0;
        r   = cli_req[o.id];
        if (o.busy && r.rd_req) begin
            cmd.en   = 1'b1;
            cmd.addr = (port_b && o.id == vrf_arb_pkg::CLI_VPU) ? vpu_src2_addr : r.rd_addr;
        end else if (o.busy && r.wr_req) begin
            cmd.en   = 1'b1;
            cmd.we   = 1'b1;
            cmd.addr = r.wr_addr;
            cmd.din  = r.wr_data;
        end
        return cmd;
    endfunction

    task automatic check_val(string name, logic [$bits(vrf_arb_pkg::bram_req_t)-1:0] got,
            logic [$bits(vrf_arb_pkg::bram_req_t)-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic cmp_cycle();
        logic [NC-1:0] own;
        logic [NC-1:0] routed;
        logic [NC-1:0] exp_rd;
        logic [NC-1:0] exp_wr;
        for (int c = 0; c < NC; c++) begin
            own[c]    = owns(ref_a, c) || owns(ref_b, c);
            // VPU sees port B only on its second operand output
            routed[c] = owns(ref_a, c) || (owns(ref_b, c) && c != 0);
            exp_rd[c] = own[c] && cli_req[c].rd_req;
            exp_wr[c] = own[c] && cli_req[c].wr_req && !cli_req[c].rd_req;
        end
        check_val("cli_rd_gnt_o", rd_gnt, exp_rd);
        check_val("cli_wr_gnt_o", wr_gnt, exp_wr);
        check_val("bram_a_o", bram_a, exp_cmd(ref_a, 1'b0));
        check_val("bram_b_o", bram_b, exp_cmd(ref_b, 1'b1));
        for (int c = 0; c < NC; c++) begin
            // dout trails the address by one edge
            if (!routed[c]) begin
                check_val($sformatf("cli_rd_data_o[%0d]", c), rd_data[c], '0);
            end else if (exp_rd[c] && prev_rd[c] && prev_addr[c] == cli_req[c].rd_addr) begin
                check_val($sformatf("cli_rd_data_o[%0d]", c), rd_data[c], prev_data[c]);
            end
            prev_rd[c]   = exp_rd[c];
            prev_addr[c] = cli_req[c].rd_addr;
            prev_data[c] = mem[cli_req[c].rd_addr];
        end
        if (!owns(ref_b, 0)) begin
            check_val("vpu_src2_data_o", src2_data, '0);
        end else if (prev_src2 && exp_rd[0]) begin
            check_val("vpu_src2_data_o", src2_data, prev_src2_data);
        end
        prev_src2      = owns(ref_b, 0) && exp_rd[0];
        prev_src2_data = mem[vpu_src2_addr];
    endtask

    always @(negedge clk) begin
        if (cmp_en) begin
            #1;
            cmp_cycle();
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [DW-1:0] rand_word();
        logic [DW-1:0] w;
        for (int i = 0; i < DW / 32; i++) begin
            w[i*32 +: 32] = $random(seed);
        end
        return w;
    endfunction

    task automatic set_req(int c, logic rd, logic wr, logic [AW-1:0] addr, logic [DW-1:0] data);
        cli_req[c].rd_req  = rd;
        cli_req[c].wr_req  = wr;
        cli_req[c].rd_addr = addr;
        cli_req[c].wr_addr = addr;
        cli_req[c].wr_data = data;
    endtask

    // starts right after driving on a falling edge
    task automatic wait_gnt(int c, logic rd, int limit, output int cyc);
        cyc = 0;
        #1;
        while (!(rd ? rd_gnt[c] : wr_gnt[c])) begin
            if (cyc == limit) begin
                $display("client %0d got no grant within %0d cycles", c, limit);
                errors++;
                break;
            end
            @(negedge clk);
            #1;
            cyc++;
        end
    endtask

    task automatic end_test(string name, int err_before);
        tests++;
        $display("test %0d %s: %s", tests, name, errors == err_before ? "ok" : "errors");
    endtask

    initial begin
        #(2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("timeout, the run did not finish within %0d cycles", 2 * TOTAL_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int            e0;
        int            cyc;
        int            tail [NC];
        logic          kind;
        logic [NC-1:0] active;
        logic [NC-1:0] got;
        logic [AW-1:0] addr;
        logic [DW-1:0] word;
        clk           = 1'b0;
        rst_n         = 1'b0;
        cmp_en        = 1'b0;
        prev_rd       = '0;
        prev_src2     = 1'b0;
        vpu_src2_addr = '0;
        for (int c = 0; c < NC; c++) begin
            cli_req[c] = '0;
        end
        for (int i = 0; i < (1 << AW); i++) begin
            mem[i] = {32{32'(i) * 32'h9e37_79b1}};
        end

        // reset
        e0 = errors;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);
        cmp_en = 1'b1;
        @(negedge clk);
        #1;
        check_val("cli_rd_gnt_o/cli_wr_gnt_o", {rd_gnt, wr_gnt}, '0);
        check_val("bram_a_o.en/we", {bram_a.en, bram_a.we}, '0);
        check_val("bram_b_o.en/we", {bram_b.en, bram_b.we}, '0);
        end_test("reset", e0);

        // MPU write, then read back
        e0   = errors;
        addr = AW'($random(seed));
        word = rand_word();
        @(negedge clk);
        set_req(1, 1'b0, 1'b1, addr, word);
        wait_gnt(1, 1'b0, 10, cyc);
        check_val("cli_wr_gnt_o[1] delay", cyc, 1);
        @(negedge clk);
        set_req(1, 1'b0, 1'b0, '0, '0);
        @(negedge clk);
        set_req(1, 1'b1, 1'b0, addr, '0);
        wait_gnt(1, 1'b1, 10, cyc);
        check_val("cli_rd_gnt_o[1] delay", cyc, 1);
        @(negedge clk);
        #1;
        check_val("cli_rd_data_o[1]", rd_data[1], word);
        @(negedge clk);
        set_req(1, 1'b0, 1'b0, '0, '0);
        end_test("write then read back", e0);

        // dual operand VPU read
        e0   = errors;
        addr = AW'($random(seed));
        @(negedge clk);
        vpu_src2_addr = AW'($random(seed));
        set_req(0, 1'b1, 1'b0, addr, '0);
        wait_gnt(0, 1'b1, 10, cyc);
        check_val("bram_a_o/bram_b_o en addr", {bram_a.en, bram_a.addr, bram_b.en, bram_b.addr},
                  {1'b1, addr, 1'b1, vpu_src2_addr});
        @(negedge clk);
        #1;
        check_val("cli_rd_data_o[0]", rd_data[0], mem[addr]);
        check_val("vpu_src2_data_o", src2_data, mem[vpu_src2_addr]);
        @(negedge clk);
        set_req(0, 1'b0, 1'b0, '0, '0);
        end_test("dual operand VPU read", e0);

        // MA holds port A, VPU takes B, router starves until B frees
        e0 = errors;
        @(negedge clk);
        set_req(2, 1'b0, 1'b1, AW'(5), rand_word());
        wait_gnt(2, 1'b0, 10, cyc);
        @(negedge clk);
        set_req(0, 1'b0, 1'b1, AW'(6), rand_word());
        set_req(3, 1'b0, 1'b1, AW'(7), rand_word());
        wait_gnt(0, 1'b0, 10, cyc);
        check_val("bram_b_o.we/addr", {bram_b.we, bram_b.addr}, {1'b1, AW'(6)});
        repeat (3) begin
            @(negedge clk);
            #1;
            check_val("cli_wr_gnt_o", wr_gnt, 4'b0101);
        end
        @(negedge clk);
        set_req(0, 1'b0, 1'b0, '0, '0);
        wait_gnt(3, 1'b0, 10, cyc);
        check_val("bram_b_o.addr", bram_b.addr, AW'(7));
        @(negedge clk);
        set_req(2, 1'b0, 1'b0, '0, '0);
        set_req(3, 1'b0, 1'b0, '0, '0);
        end_test("priority and holding", e0);

        // random contention, small address range for collisions
        e0     = errors;
        active = '0;
        got    = '0;
        repeat (RAND_CYCLES) begin
            @(negedge clk);
            for (int c = 0; c < NC; c++) begin
                if (active[c]) begin
                    if (got[c] && tail[c] == 0) begin
                        set_req(c, 1'b0, 1'b0, '0, '0);
                        active[c] = 1'b0;
                    end else if (got[c]) begin
                        tail[c]--;
                    end
                end else if ($random(seed) % 3 == 0) begin
                    kind = $random(seed);
                    set_req(c, kind, !kind, AW'($random(seed) & 15), rand_word());
                    if (c == 0) begin
                        vpu_src2_addr = AW'($random(seed) & 15);
                    end
                    tail[c]   = $unsigned($random(seed)) % 4;
                    active[c] = 1'b1;
                    got[c]    = 1'b0;
                end
            end
            #1;
            got = got | rd_gnt | wr_gnt;
        end
        @(negedge clk);
        for (int c = 0; c < NC; c++) begin
            set_req(c, 1'b0, 1'b0, '0, '0);
        end
        repeat (3) @(negedge clk);
        end_test("random contention", e0);

        errors += UUT.u_chk.assert_fails;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: vrf_arbiter.f
verilog/vrf_arb_pkg.sv
verilog/port_owner_ctrl.sv
verilog/bram_port_mux.sv
verilog/grant_return.sv
verilog/vrf_arbiter.sv
verif/vrf_arbiter_chk.sv
verif/tb_vrf_arbiter.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the VRF arbiter testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_vrf_arbiter \
    -f vrf_arbiter.f -o sim_vrf_arbiter

# keep going past assertion errors so the testbench prints its summary
./obj_dir/sim_vrf_arbiter +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation passed" sim.log; then
    exit 0
fi
exit 1
